/* common/scan_if.sv */
`timescale 1ns/10ps

interface scan_if;
	import snake_pkg::*;

	// current scan position
	coord_x_t x;
	coord_y_t y;

	// per-pixel object flags
	logic head_hit;
	logic body_hit;
	logic apple_hit;

	modport scanner (output x, output y, input head_hit, input body_hit, input apple_hit);

	modport snake (input x, input y, output head_hit, output body_hit);

	modport apple (input x, input y, input head_hit, output apple_hit);

endinterface

/* common/snake_pkg.sv */
package snake_pkg;

	// ############################
	// field geometry
	// ############################
	localparam int X_W = 8;
	localparam int Y_W = 7;

	typedef logic [X_W-1:0] coord_x_t;
	typedef logic [Y_W-1:0] coord_y_t;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int SPRITE = 3;
	localparam int GRID_STEP = 3;

	// legal top-left corner of the head
	localparam coord_x_t PLAY_X_MIN = 8'd5;
	localparam coord_x_t PLAY_X_MAX = 8'd152;
	localparam coord_y_t PLAY_Y_MIN = 7'd5;
	localparam coord_y_t PLAY_Y_MAX = 7'd107;

	typedef struct packed {
		coord_x_t x_min;
		coord_x_t x_max;
		coord_y_t y_min;
		coord_y_t y_max;
	} box_t;

	// wall band is outer box minus inner box
	localparam box_t WALL_OUT = '{x_min: 8'd2, x_max: 8'd157, y_min: 7'd2, y_max: 7'd112};
	localparam box_t WALL_IN = '{x_min: 8'd5, x_max: 8'd154, y_min: 7'd5, y_max: 7'd109};

	localparam coord_x_t HEAD_START_X = 8'd8;
	localparam coord_y_t HEAD_START_Y = 7'd8;
	localparam coord_x_t APPLE_START_X = 8'd16;
	localparam coord_y_t APPLE_START_Y = 7'd17;

	localparam int MAX_LEN = 32;
	localparam int SELF_HIT_MIN = 5;
	localparam int SCORE_W = 13;

	// ############################
	// types and codes
	// ############################
	typedef logic [3:0] speed_t;

	typedef enum logic [7:0] {NONE, UP, LEFT, DOWN, RIGHT} heading_t;

	typedef enum logic [2:0] {INIT, MENU, GAME_INIT, GAME_WAIT, PLAY, GAME_OVER} game_state_t;

	// r, g, b
	typedef logic [2:0] colour_t;
	localparam colour_t BLACK = 3'b000;
	localparam colour_t RED = 3'b100;
	localparam colour_t GREEN = 3'b010;
	localparam colour_t BLUE = 3'b001;

	localparam logic [7:0] KEY_EXTEND = 8'hE0;
	localparam logic [7:0] KEY_RELEASE = 8'hF0;
	localparam logic [7:0] KEY_UP = 8'h75;
	localparam logic [7:0] KEY_LEFT = 8'h6B;
	localparam logic [7:0] KEY_DOWN = 8'h72;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_1 = 8'h16;
	localparam logic [7:0] KEY_2 = 8'h1E;
	localparam logic [7:0] KEY_3 = 8'h26;

	// pixel inside a square object at ox, oy
	function automatic logic in_sprite(coord_x_t px, coord_y_t py, coord_x_t ox, coord_y_t oy);
		return (px >= ox) && (int'(px) <= int'(ox) + SPRITE - 1)
			&& (py >= oy) && (int'(py) <= int'(oy) + SPRITE - 1);
	endfunction

endpackage

/* compile.f */
common/snake_pkg.sv
common/scan_if.sv
hw/ps2_keyboard.sv
hw/game_fsm.sv
hw/frame_render.sv
game/snake_body.sv
game/apple_field.sv
hw/snake_top.sv
verif/snake_properties.sv
verif/snake_tb.sv

/* game/apple_field.sv */
`timescale 1ns/10ps

module apple_field (
	input logic clk,
	input logic reset,
	scan_if.apple hits,
	input logic init_game,
	output logic eaten,
	output logic [snake_pkg::SCORE_W-1:0] score
);
	import snake_pkg::*;

	localparam coord_x_t CAND_X_MIN = 8'd7;
	localparam coord_x_t CAND_X_MAX = 8'd151;

	coord_x_t cand_x;
	coord_y_t cand_y;
	coord_x_t apple_x;
	coord_y_t apple_y;
	logic eat;

	// grid walk used as the next apple spot
	always_ff @(posedge clk) begin
		if (reset) begin
			cand_x <= CAND_X_MIN;
			cand_y <= PLAY_Y_MIN;
		end else if (cand_x == CAND_X_MAX) begin
			cand_x <= CAND_X_MIN;
			cand_y <= (cand_y == PLAY_Y_MAX) ? PLAY_Y_MIN : cand_y + Y_W'(GRID_STEP);
		end else begin
			cand_x <= cand_x + X_W'(GRID_STEP);
		end
	end

	assign hits.apple_hit = in_sprite(hits.x, hits.y, apple_x, apple_y);
	assign eat = hits.head_hit && hits.apple_hit;

	always_ff @(posedge clk) begin
		if (init_game) begin
			apple_x <= APPLE_START_X;
			apple_y <= APPLE_START_Y;
		end else if (eat) begin
			apple_x <= cand_x;
			apple_y <= cand_y;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			eaten <= 1'b0;
			score <= '0;
		end else begin
			eaten <= eat;
			if (init_game)
				score <= '0;
			else if (eat)
				score <= score + 1'b1;
		end
	end

endmodule

/* game/snake_body.sv */
`timescale 1ns/10ps

module snake_body (
	input logic clk,
	input logic reset,
	scan_if.snake hits,
	input snake_pkg::heading_t heading,
	input logic init_game,
	input logic init_head,
	input logic step,
	input logic eaten,
	output logic crash
);
	import snake_pkg::*;

	localparam int LEN_W = $clog2(MAX_LEN);

	coord_x_t seg_x [MAX_LEN];
	coord_y_t seg_y [MAX_LEN];
	logic [LEN_W-1:0] len;
	heading_t dir;
	heading_t dir_next;
	logic grow;
	logic placed;
	logic self_hit;
	logic out_of_field;
	logic scan_origin;

	function automatic logic reverses(heading_t a, heading_t b);
		return (a == UP && b == DOWN) || (a == DOWN && b == UP)
			|| (a == LEFT && b == RIGHT) || (a == RIGHT && b == LEFT);
	endfunction

	// a u-turn keeps the old heading
	always_comb begin
		dir_next = dir;
		if (heading != NONE && !reverses(heading, dir))
			dir_next = heading;
	end

	// ############################
	// segment store, 0 is the head
	// ############################
	always_ff @(posedge clk) begin
		if (init_head) begin
			seg_x[0] <= HEAD_START_X;
			seg_y[0] <= HEAD_START_Y;
		end else if (step) begin
			for (int i = MAX_LEN - 1; i > 0; i--) begin
				seg_x[i] <= seg_x[i-1];
				seg_y[i] <= seg_y[i-1];
			end
			case (dir_next)
				UP: seg_y[0] <= seg_y[0] - Y_W'(GRID_STEP);
				DOWN: seg_y[0] <= seg_y[0] + Y_W'(GRID_STEP);
				LEFT: seg_x[0] <= seg_x[0] - X_W'(GRID_STEP);
				RIGHT: seg_x[0] <= seg_x[0] + X_W'(GRID_STEP);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset || init_game) begin
			len <= '0;
			dir <= NONE;
			grow <= 1'b0;
			placed <= 1'b0;
		end else begin
			if (init_head)
				placed <= 1'b1;
			if (step) begin
				dir <= dir_next;
				grow <= 1'b0;
				if (grow && len < LEN_W'(MAX_LEN - 1))
					len <= len + 1'b1;
			end
			// apple eaten during a step grows on the next one
			if (eaten)
				grow <= 1'b1;
		end
	end

	always_comb begin
		hits.head_hit = placed && in_sprite(hits.x, hits.y, seg_x[0], seg_y[0]);
		hits.body_hit = 1'b0;
		self_hit = 1'b0;
		for (int i = 1; i < MAX_LEN; i++) begin
			if (placed && i <= len && in_sprite(hits.x, hits.y, seg_x[i], seg_y[i])) begin
				hits.body_hit = 1'b1;
				if (i >= SELF_HIT_MIN)
					self_hit = 1'b1;
			end
		end
	end

	assign out_of_field = (seg_x[0] < PLAY_X_MIN) || (seg_x[0] > PLAY_X_MAX)
		|| (seg_y[0] < PLAY_Y_MIN) || (seg_y[0] > PLAY_Y_MAX);
	assign scan_origin = (hits.x == '0) && (hits.y == '0);

	// wall check once per scan, body check on any shared pixel
	always_ff @(posedge clk) begin
		if (reset)
			crash <= 1'b0;
		else
			crash <= placed && ((scan_origin && out_of_field) || (hits.head_hit && self_hit));
	end

endmodule

/* hw/frame_render.sv */
`timescale 1ns/10ps

module frame_render (
	input logic clk,
	input logic reset,
	scan_if.scanner hits,
	input logic in_game,
	output snake_pkg::coord_x_t pixel_x,
	output snake_pkg::coord_y_t pixel_y,
	output snake_pkg::colour_t rgb
);
	import snake_pkg::*;

	logic in_outer;
	logic in_inner;
	logic wall;
	colour_t colour;

	// raster scan, one pixel per clock
	always_ff @(posedge clk) begin
		if (reset) begin
			hits.x <= '0;
			hits.y <= '0;
		end else if (hits.x == X_W'(SCREEN_W)) begin
			hits.x <= '0;
			hits.y <= (hits.y == Y_W'(SCREEN_H)) ? '0 : hits.y + 1'b1;
		end else begin
			hits.x <= hits.x + 1'b1;
		end
	end

	assign in_outer = (hits.x >= WALL_OUT.x_min) && (hits.x <= WALL_OUT.x_max)
		&& (hits.y >= WALL_OUT.y_min) && (hits.y <= WALL_OUT.y_max);
	assign in_inner = (hits.x >= WALL_IN.x_min) && (hits.x <= WALL_IN.x_max)
		&& (hits.y >= WALL_IN.y_min) && (hits.y <= WALL_IN.y_max);
	assign wall = in_outer && !in_inner;

	// snake over apple over wall
	always_comb begin
		colour = BLACK;
		if (in_game) begin
			if (hits.head_hit || hits.body_hit)
				colour = GREEN;
			else if (hits.apple_hit)
				colour = RED;
			else if (wall)
				colour = BLUE;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pixel_x <= '0;
			pixel_y <= '0;
			rgb <= BLACK;
		end else begin
			pixel_x <= hits.x;
			pixel_y <= hits.y;
			rgb <= colour;
		end
	end

endmodule

/* hw/game_fsm.sv */
`timescale 1ns/10ps

module game_fsm #(
	parameter int FRAME_TICKS = 840000
) (
	input logic clk,
	input logic reset,
	input snake_pkg::heading_t heading,
	input logic [1:0] speed_key,
	input logic crash,
	output snake_pkg::game_state_t state,
	output logic init_game,
	output logic init_head,
	output logic step,
	output logic in_menu,
	output logic in_game,
	output logic game_over
);
	import snake_pkg::*;

	localparam int TICK_W = $clog2(FRAME_TICKS);

	game_state_t next_state;
	logic [TICK_W-1:0] tick_cnt;
	logic frame_tick;
	speed_t speed;
	speed_t div_cnt;

	always_comb begin
		next_state = state;
		case (state)
			INIT: next_state = MENU;
			MENU: if (speed_key != 2'd0) next_state = GAME_INIT;
			GAME_INIT: next_state = GAME_WAIT;
			GAME_WAIT: if (heading != NONE) next_state = PLAY;
			PLAY: if (crash) next_state = GAME_OVER;
			GAME_OVER: next_state = GAME_OVER;
			default: next_state = INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= INIT;
		else
			state <= next_state;
	end

	// ############################
	// speed and step timer
	// ############################
	always_ff @(posedge clk) begin
		if (reset) begin
			speed <= 4'd1;
		end else if (state == MENU) begin
			case (speed_key)
				2'd1: speed <= 4'd4;
				2'd2: speed <= 4'd2;
				2'd3: speed <= 4'd1;
				default: speed <= speed;
			endcase
		end
	end

	assign frame_tick = (tick_cnt == TICK_W'(FRAME_TICKS - 1));

	always_ff @(posedge clk) begin
		if (reset || frame_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// frames since the last step
	always_ff @(posedge clk) begin
		if (reset || state != PLAY)
			div_cnt <= '0;
		else if (frame_tick)
			div_cnt <= (div_cnt == speed - 1'b1) ? '0 : div_cnt + 1'b1;
	end

	assign step = (state == PLAY) && frame_tick && (div_cnt == speed - 1'b1);

	assign init_game = (state == GAME_INIT);
	assign init_head = (state == GAME_WAIT);
	assign in_menu = (state == MENU);
	assign in_game = (state == GAME_INIT) || (state == GAME_WAIT) || (state == PLAY);
	assign game_over = (state == GAME_OVER);

endmodule

/* hw/ps2_keyboard.sv */
`timescale 1ns/10ps

module ps2_keyboard (
	input logic clk,
	input logic reset,
	input logic ps2_clk,
	input logic ps2_data,
	output snake_pkg::heading_t heading,
	output logic [1:0] speed_key
);
	import snake_pkg::*;

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic clk_rise;
	logic [3:0] bit_cnt;
	logic [10:0] frame;
	logic [10:0] frame_next;
	logic [7:0] code;
	logic [7:0] prefix;

	// ps2 lines into clk domain, idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign clk_rise = clk_sync[1] && !clk_prev;

	// lsb first, start bit ends up in bit 0
	assign frame_next = {data_sync[1], frame[10:1]};
	assign code = frame_next[8:1];

	always_ff @(posedge clk) begin
		if (clk_rise)
			frame <= frame_next;
	end

	// ############################
	// byte decode
	// ############################
	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			prefix <= '0;
			heading <= NONE;
			speed_key <= 2'd0;
		end else if (clk_rise) begin
			if (bit_cnt == 4'd10) begin
				bit_cnt <= '0;
				prefix <= code;
				if (prefix == KEY_EXTEND) begin
					case (code)
						KEY_UP: heading <= UP;
						KEY_LEFT: heading <= LEFT;
						KEY_DOWN: heading <= DOWN;
						KEY_RIGHT: heading <= RIGHT;
						default: heading <= NONE;
					endcase
				end else if (prefix == KEY_RELEASE) begin
					case (code)
						KEY_1: speed_key <= 2'd1;
						KEY_2: speed_key <= 2'd2;
						KEY_3: speed_key <= 2'd3;
						default: speed_key <= 2'd0;
					endcase
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

/* hw/snake_top.sv */
`timescale 1ns/10ps

module snake_top #(
	parameter int FRAME_TICKS = 840000
) (
	input logic clk,
	input logic reset,
	input logic ps2_clk,
	input logic ps2_data,
	output snake_pkg::coord_x_t pixel_x,
	output snake_pkg::coord_y_t pixel_y,
	output snake_pkg::colour_t rgb,
	output logic in_menu,
	output logic in_game,
	output logic game_over,
	output logic [snake_pkg::SCORE_W-1:0] score
);
	import snake_pkg::*;

	heading_t heading;
	logic [1:0] speed_key;
	logic init_game;
	logic init_head;
	logic step;
	logic crash;
	logic eaten;

	scan_if hits ();

	ps2_keyboard u_keyboard (
		.clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.heading(heading), .speed_key(speed_key)
	);

	game_fsm #(.FRAME_TICKS(FRAME_TICKS)) u_fsm (
		.clk(clk), .reset(reset), .heading(heading), .speed_key(speed_key),
		.crash(crash), .state(), .init_game(init_game), .init_head(init_head),
		.step(step), .in_menu(in_menu), .in_game(in_game), .game_over(game_over)
	);

	frame_render u_render (
		.clk(clk), .reset(reset), .hits(hits.scanner), .in_game(in_game),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .rgb(rgb)
	);

	snake_body u_snake (
		.clk(clk), .reset(reset), .hits(hits.snake), .heading(heading),
		.init_game(init_game), .init_head(init_head), .step(step),
		.eaten(eaten), .crash(crash)
	);

	apple_field u_apple (
		.clk(clk), .reset(reset), .hits(hits.apple), .init_game(init_game),
		.eaten(eaten), .score(score)
	);

endmodule

/* verif/snake_properties.sv */
`timescale 1ns/10ps

module snake_properties (
	input logic clk,
	input logic reset,
	input snake_pkg::game_state_t state,
	input logic step,
	input logic init_game,
	input logic init_head,
	input logic in_menu,
	input logic in_game,
	input logic game_over
);
	import snake_pkg::*;

	int fail_count = 0;

	// one status flag once INIT is over
	status_onehot: assert property (@(posedge clk) disable iff (reset)
		(state != INIT) |-> $onehot({in_menu, in_game, game_over}))
		else begin
			$error("status flags not one-hot outside INIT");
			fail_count++;
		end

	// play is the game phase after both init strobes
	step_in_play: assert property (@(posedge clk) disable iff (reset)
		step |-> (in_game && !init_game && !init_head))
		else begin
			$error("step pulse outside PLAY");
			fail_count++;
		end

	// only reset leaves game over
	over_holds: assert property (@(posedge clk) disable iff (reset)
		game_over |=> game_over)
		else begin
			$error("game_over dropped without reset");
			fail_count++;
		end

endmodule

bind game_fsm snake_properties props (
	.clk(clk), .reset(reset), .state(state), .step(step),
	.init_game(init_game), .init_head(init_head),
	.in_menu(in_menu), .in_game(in_game), .game_over(game_over)
);

/* verif/snake_stim.txt */
# one step per line, operands in hex
# send byte | wait sig value cycles | expect sig value | least sig value | pixel x y colour scans | done test
expect in_menu 1
expect in_game 0
expect game_over 0
expect score 0
done 1
send F0
send 16
wait in_game 1 400
pixel 09 09 2 2
pixel 11 12 4 2
pixel 03 32 1 2
done 2
send E0
send 72
pixel 09 12 2 20
done 3
send E0
send 74
wait score 1 40000
done 4
send E0
send 6B
wait game_over 1 500000
expect in_game 0
least score 1
done 5

/* verif/snake_tb.sv */
`timescale 1ns/10ps

module snake_tb;
	import snake_pkg::*;

	localparam int SCAN_CYCLES = 161 * 121 + 16;
	// last legal head column before the right wall
	localparam int LAST_HEAD_X = 152;

	logic clk;
	logic reset;
	logic ps2_clk;
	logic ps2_data;
	coord_x_t pixel_x;
	coord_y_t pixel_y;
	colour_t rgb;
	logic in_menu;
	logic in_game;
	logic game_over;
	logic [SCORE_W-1:0] score;
	coord_x_t snake_x_max;

	int errors = 0;
	int test_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;

	snake_top #(.FRAME_TICKS(20000)) uut (
		.clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .rgb(rgb), .in_menu(in_menu),
		.in_game(in_game), .game_over(game_over), .score(score)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] output_value(string name);
		case (name)
			"in_menu": return 32'(in_menu);
			"in_game": return 32'(in_game);
			"game_over": return 32'(game_over);
			"score": return 32'(score);
			"rgb": return 32'(rgb);
			default: return 'x;
		endcase
	endfunction

	// rightmost snake pixel drawn while a game runs
	always @(negedge clk) begin
		if (reset)
			snake_x_max = '0;
		else if (in_game && rgb === GREEN && pixel_x > snake_x_max)
			snake_x_max = pixel_x;
	end

	// the run ends with the snake at the right wall
	always @(posedge game_over) begin
		if (int'(snake_x_max) < LAST_HEAD_X) begin
			$display("mismatch pixel_x at game over: expected at least 0x%0h, got 0x%0h",
				LAST_HEAD_X, snake_x_max);
			errors++;
		end
	end

	// ##############################
	// ps2 and check tasks
	// ##############################

	// start bit, data lsb first, odd parity and stop bit
	task automatic send_ps2_byte(input logic [7:0] data);
		logic [10:0] bits;
		int gap;
		bits = {1'b1, ~^data, data, 1'b0};
		gap = 20 + ($urandom % 40);
		repeat (gap) @(posedge clk);
		for (int i = 0; i < 11; i++) begin
			#1;
			ps2_data = bits[i];
			ps2_clk = 1'b0;
			repeat (5) @(posedge clk);
			#1;
			ps2_clk = 1'b1;
			repeat (5) @(posedge clk);
		end
		#1;
	endtask

	task automatic wait_for_value(input string name, input logic [31:0] value, input int limit);
		int count;
		count = 0;
		while (output_value(name) !== value && count < limit) begin
			@(posedge clk);
			#1;
			count++;
		end
		if (output_value(name) !== value) begin
			$display("timeout: %s did not reach 0x%0h in %0d cycles", name, value, limit);
			errors++;
		end
	endtask

	task automatic expect_value(input string name, input logic [31:0] value, input logic least);
		logic [31:0] got;
		got = output_value(name);
		if ($isunknown(got)) begin
			$display("unknown or undriven signal %s in stimulus", name);
			errors++;
		end else if (least ? !(got >= value) : (got !== value)) begin
			$display("mismatch %s: expected %s0x%0h, got 0x%0h", name,
				least ? "at least " : "", value, got);
			errors++;
		end
	endtask

	// look at the pixel once per scan until it shows the colour
	task automatic check_pixel(input coord_x_t px, input coord_y_t py, input colour_t colour,
		input int scans);
		int count;
		int tries;
		logic seen;
		colour_t last;
		seen = 1'b0;
		tries = 0;
		last = 'x;
		while (!seen && tries < scans) begin
			count = 0;
			while (!(pixel_x == px && pixel_y == py) && count < SCAN_CYCLES) begin
				@(posedge clk);
				#1;
				count++;
			end
			if (count >= SCAN_CYCLES) begin
				$display("timeout: scan never reached pixel %0d,%0d", px, py);
				errors++;
				return;
			end
			last = rgb;
			seen = (rgb === colour);
			tries++;
			@(posedge clk);
			#1;
		end
		if (!seen) begin
			$display("mismatch rgb at %0d,%0d: expected 0x%0h, got 0x%0h", px, py, colour, last);
			errors++;
		end
	endtask

	task automatic close_test(input int id);
		tests_run++;
		if (errors == test_mark) begin
			$display("test %0d: passed", id);
		end else begin
			tests_failed++;
			$display("test %0d: failed with %0d errors", id, errors - test_mark);
		end
		test_mark = errors;
	endtask

	task automatic run_script();
		int fd;
		int n;
		string line;
		string cmd;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("verif/snake_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/snake_stim.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			cmd = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%s", cmd);
			if (n < 1 || cmd.getc(0) == "#")
				continue;
			case (cmd)
				"send": begin
					n = $sscanf(line, "%s %h", cmd, a);
					send_ps2_byte(a[7:0]);
				end
				"wait": begin
					n = $sscanf(line, "%s %s %h %h", cmd, name, a, b);
					wait_for_value(name, a, int'(b));
				end
				"expect", "least": begin
					n = $sscanf(line, "%s %s %h", cmd, name, a);
					expect_value(name, a, cmd == "least");
				end
				"pixel": begin
					n = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
					check_pixel(a[X_W-1:0], b[Y_W-1:0], c[2:0], int'(d));
				end
				"done": begin
					n = $sscanf(line, "%s %h", cmd, a);
					close_test(int'(a));
				end
				default: begin
					$display("unknown stimulus command %s", cmd);
					errors++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	// ##############################
	// main sequence
	// ##############################
	initial begin
		void'($urandom(63));
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		run_script();
		if (uut.u_fsm.props.fail_count != 0) begin
			$display("assertion failures in the game FSM: %0d", uut.u_fsm.props.fail_count);
			errors += uut.u_fsm.props.fail_count;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
